// File: sim.f
hdl/fxp_pkg.sv
hdl/mul_pkg.sv
hdl/lzc.sv
hdl/recip_engine.sv
hdl/quot_scaler.sv
hdl/mul_arbiter.sv
hdl/fxp_divider.sv
verification/clk_gen.sv
verification/tb_fxp_divider.sv

// File: Makefile
# Verilator flow for the Q12.12 divider testbench
# Override any variable on the command line, e.g. make sim TOP=tb_fxp_divider

VERILATOR ?= verilator
TOP       ?= tb_fxp_divider
RTL_TOP   ?= fxp_divider
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all lint lint_rtl build sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) hdl/fxp_pkg.sv hdl/mul_pkg.sv hdl/lzc.sv \
		hdl/recip_engine.sv hdl/quot_scaler.sv hdl/mul_arbiter.sv hdl/fxp_divider.sv \
		--top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only if the pass message appears as a line of its own
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_fxp_divider.sv
/*
  Testbench for the Q12.12 fixed-point divider
  Table of directed and random divisions, integer reference model,
  in-order result checks, latency checks and a watchdog
*/
module tb_fxp_divider;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 8;
  localparam int NTAB         = 18;            // Directed rows
  localparam int NRAND        = 40;            // Random rows
  localparam int NTOT         = NTAB + NRAND;
  localparam int UNCONT_LAT   = 6;             // Start to o_valid, no contention
  localparam int TIMEOUT_CYC  = RESET_CYCLES + 20 * NTOT;

  localparam longint MASK24 = 64'hFF_FFFF;
  localparam longint SATV   = 64'h7F_FFFF;     // Largest positive Q12.12
  localparam longint K1466  = 6004;            // 1.466 * 4096, truncated
  localparam longint K10012 = 4100;            // 1.0012 * 4096, truncated
  localparam longint LIM35  = 64'h8_0000_0000; // First product that overflows Q12.12

  logic        clk;
  logic        i_rst;
  logic        i_start;
  logic [23:0] i_num;
  logic [23:0] i_den;
  logic        i_abs;
  logic        o_ready;
  logic        o_valid;
  logic [23:0] o_quot;
  logic        o_sat;

  logic [23:0] tab_num [NTOT];
  logic [23:0] tab_den [NTOT];
  logic        tab_abs [NTOT];
  logic        tab_b2b [NTOT];                 // Issue as soon as o_ready returns
  logic [24:0] tab_exp [NTOT];                 // {sat, quot} from the model

  int exp_idx [$];                             // Outstanding tests, issue order
  int exp_cyc [$];                             // Start cycle of each
  int seed     = 27;
  int cycle_cnt = 0;
  int errors   = 0;
  int accepted = 0;
  int results  = 0;
  int mon_idx;
  int mon_lat;
  logic mon_ok;

  clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (.clk(clk));

  fxp_divider i_fxp_divider (
    .clk    (clk),
    .i_rst  (i_rst),
    .i_start(i_start),
    .i_num  (i_num),
    .i_den  (i_den),
    .i_abs  (i_abs),
    .o_ready(o_ready),
    .o_valid(o_valid),
    .o_quot (o_quot),
    .o_sat  (o_sat)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Reinterpret the low 24 bits as a signed word
  function automatic longint wrap24(input longint v);
    longint w;
    w = v & MASK24;
    if (w >= 64'h80_0000) w = w - 64'h100_0000;
    return w;
  endfunction

  // Reference divider, returns {sat, quot}
  function automatic logic [24:0] expected_div(input logic [23:0] num, input logic [23:0] den,
                                               input logic abs);
    logic [23:0] den_m, num_m, q;
    longint      a, b, c, d, e, r4, rs, prod, mag;
    int          lz;
    logic        recip_sat, sat, neg;
    den_m = den[23] ? (~den + 24'd1) : den;
    num_m = num[23] ? (~num + 24'd1) : num;
    lz = 0;
    while (lz < 24) begin                      // Leading zeros, 24 for zero
      if (den_m[23 - lz]) break;
      lz++;
    end
    if (lz <= 12) a = longint'(den_m) >> (12 - lz);   // Into [0.5,1)
    else a = (longint'(den_m) << (lz - 12)) & MASK24;
    b = wrap24(K1466 - a);
    c = wrap24((a * b) >>> 12);
    d = wrap24(K10012 - c);
    e = wrap24((d * b) >>> 12) & MASK24;
    r4 = (e >= 64'h40_0000) ? SATV : e * 4;    // Times four, saturated
    if (lz <= 12) rs = r4 >> (12 - lz);        // Undo the normalisation
    else rs = r4 << (lz - 12);
    recip_sat = rs > MASK24;
    if (recip_sat) rs = SATV;
    prod = wrap24(longint'(num_m)) * wrap24(rs);
    sat  = (prod < 0) || (prod >= LIM35) || (recip_sat && num_m != 24'd0);
    mag  = sat ? SATV : ((prod >>> 12) & MASK24);
    neg  = (num[23] ^ den[23]) && !abs;
    q    = neg ? 24'(-mag) : 24'(mag);
    return {sat, q};
  endfunction

  task automatic set_row(input int idx, input logic [23:0] num, input logic [23:0] den,
                         input logic abs, input logic b2b);
    tab_num[idx] = num;
    tab_den[idx] = den;
    tab_abs[idx] = abs;
    tab_b2b[idx] = b2b;
  endtask

  task automatic load_table();
    int r, sh;
    int rn, rd;
    set_row(0,  24'h003000, 24'h001800, 1'b0, 1'b0);  // 3.0 / 1.5
    set_row(1,  24'h001000, 24'h004000, 1'b0, 1'b0);  // 1.0 / 4.0
    set_row(2,  24'h007400, 24'h002000, 1'b0, 1'b0);  // 7.25 / 2.0
    set_row(3,  24'hFFD000, 24'h001800, 1'b0, 1'b0);  // Signs, i_abs low
    set_row(4,  24'h003000, 24'hFFE800, 1'b0, 1'b0);
    set_row(5,  24'hFFD000, 24'hFFE800, 1'b0, 1'b0);
    set_row(6,  24'hFFD000, 24'h001800, 1'b1, 1'b0);  // Same with i_abs high
    set_row(7,  24'h003000, 24'hFFE800, 1'b1, 1'b0);
    set_row(8,  24'hFFD000, 24'hFFE800, 1'b1, 1'b0);
    set_row(9,  24'h7D0000, 24'h000029, 1'b0, 1'b0);  // 2000 / 0.01
    set_row(10, 24'h830000, 24'h000029, 1'b0, 1'b0);  // -2000 / 0.01
    set_row(11, 24'h001000, 24'h000000, 1'b0, 1'b0);  // Zero denominator
    set_row(12, 24'hFFF000, 24'h000001, 1'b0, 1'b0);  // Reciprocal saturates
    set_row(13, 24'h005000, 24'h003000, 1'b0, 1'b1);  // Back to back from here
    set_row(14, 24'hFF6000, 24'h000C00, 1'b0, 1'b1);
    set_row(15, 24'h064000, 24'hFF9000, 1'b0, 1'b1);
    set_row(16, 24'h000000, 24'h002800, 1'b0, 1'b0);  // Zero numerator
    set_row(17, 24'h000000, 24'h000000, 1'b0, 1'b1);
    for (int k = NTAB; k < NTOT; k++) begin
      r  = $random(seed);
      sh = $random(seed) & 15;                       // Spread the magnitudes
      rn = r >>> sh;
      r  = $random(seed);
      sh = $random(seed) & 15;
      rd = r >>> sh;
      r  = $random(seed);
      set_row(k, rn[23:0], rd[23:0], r[0], r[1]);
    end
  endtask

  // Wait, at edge plus 1 ns, until every result is out
  task automatic wait_drain();
    while (exp_idx.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic issue(input int idx);
    while (!o_ready) begin
      @(posedge clk);
      #1;
    end
    i_num   = tab_num[idx];
    i_den   = tab_den[idx];
    i_abs   = tab_abs[idx];
    i_start = 1'b1;
    @(posedge clk);                                  // Accepting edge
    #1;
    exp_idx.push_back(idx);
    exp_cyc.push_back(cycle_cnt - 1);                // Start cycle, before the accepting edge
    accepted++;
    if (o_ready) begin
      $display("MISMATCH at %0t: test %0d o_ready high while engine busy", $time, idx);
      errors++;
    end
    if (tab_b2b[idx]) begin
      i_num = ~tab_num[idx];                         // Busy, so this start is dropped
      i_den = tab_den[idx] ^ 24'h00F0F0;
      @(posedge clk);
      #1;
    end
    i_start = 1'b0;
  endtask

  // Results are checked in issue order, away from the clock edge
  always @(negedge clk) begin
    if (!i_rst && o_valid) begin
      results++;
      if (exp_idx.size() == 0) begin
        $display("ERROR at %0t: o_valid pulsed with no division outstanding", $time);
        errors++;
      end else begin
        mon_idx = exp_idx.pop_front();
        mon_lat = cycle_cnt - exp_cyc.pop_front();
        mon_ok  = 1'b1;
        if (o_quot != tab_exp[mon_idx][23:0]) begin
          $display("MISMATCH at %0t: test %0d quot %h expected %h", $time, mon_idx, o_quot,
                   tab_exp[mon_idx][23:0]);
          mon_ok = 1'b0;
        end
        if (o_sat != tab_exp[mon_idx][24]) begin
          $display("MISMATCH at %0t: test %0d sat %0d expected %0d", $time, mon_idx, o_sat,
                   tab_exp[mon_idx][24]);
          mon_ok = 1'b0;
        end
        if (!tab_b2b[mon_idx] && mon_lat != UNCONT_LAT) begin
          $display("MISMATCH at %0t: test %0d latency %0d expected %0d", $time, mon_idx,
                   mon_lat, UNCONT_LAT);
          mon_ok = 1'b0;
        end
        if (!mon_ok) errors++;
        $display("test %0d num=%h den=%h abs=%0d quot=%h sat=%0d latency=%0d %s", mon_idx,
                 tab_num[mon_idx], tab_den[mon_idx], tab_abs[mon_idx], o_quot, o_sat, mon_lat,
                 mon_ok ? "ok" : "FAIL");
      end
    end
  end

  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("ERROR: run timed out after %0d cycles, a result never arrived", TIMEOUT_CYC);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    i_rst   = 1'b1;
    i_start = 1'b0;
    i_num   = '0;
    i_den   = '0;
    i_abs   = 1'b0;
    load_table();
    for (int k = 0; k < NTOT; k++) begin
      tab_exp[k] = expected_div(tab_num[k], tab_den[k], tab_abs[k]);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    i_rst = 1'b0;
    for (int k = 0; k < NTOT; k++) begin
      if (!tab_b2b[k]) wait_drain();                 // Uncontended issue
      issue(k);
    end
    wait_drain();
    repeat (10) @(posedge clk);                      // Catch stray o_valid pulses
    #1;
    if (results != accepted) begin
      $display("ERROR: %0d results for %0d accepted starts", results, accepted);
      errors++;
    end
    $display("tests=%0d accepted=%0d results=%0d errors=%0d", NTOT, accepted, results, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: verification/clk_gen.sv
/*
  Testbench clock generator
  Free-running clock, 100 ns period by default
*/
module clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  initial clk = 1'b0;

  // Half period per phase
  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: hdl/fxp_divider.sv
/*
  Q12.12 fixed-point divider
  num * recip(den), reciprocal engine and scaler share one multiplier
*/
module fxp_divider (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_start,
  input  logic [fxp_pkg::FXP_W-1:0] i_num,
  input  logic [fxp_pkg::FXP_W-1:0] i_den,
  input  logic                      i_abs,
  output logic                      o_ready,
  output logic                      o_valid,
  output logic [fxp_pkg::FXP_W-1:0] o_quot,
  output logic                      o_sat
);

  logic [mul_pkg::MUL_NREQ-1:0] mul_req, mul_valid;
  logic [mul_pkg::MUL_PW-1:0]   product;
  logic [fxp_pkg::FXP_W-1:0]    eng_op_a, eng_op_b, sc_op_a, sc_op_b;
  logic                         recip_valid, recip_sat, den_neg;
  logic [fxp_pkg::FXP_W-1:0]    recip;
  logic [fxp_pkg::FXP_W-1:0]    num_r;       // Numerator of the engine's item
  logic                         abs_r;

  // Engine carries only the reciprocal, so keep the rest here
  always_ff @(posedge clk) begin
    if (i_start && o_ready) begin
      num_r <= i_num;
      abs_r <= i_abs;
    end
  end

  recip_engine u_recip_engine (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_start      (i_start),
    .i_den        (i_den),
    .o_ready      (o_ready),
    .o_req        (mul_req[mul_pkg::MUL_REQ_RECIP]),
    .o_op_a       (eng_op_a),
    .o_op_b       (eng_op_b),
    .i_mul_valid  (mul_valid[mul_pkg::MUL_REQ_RECIP]),
    .i_product    (product),
    .o_recip_valid(recip_valid),
    .o_recip      (recip),
    .o_recip_sat  (recip_sat),
    .o_den_neg    (den_neg)
  );

  quot_scaler u_quot_scaler (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_load     (recip_valid),
    .i_num      (num_r),
    .i_recip    (recip),
    .i_recip_sat(recip_sat),
    .i_den_neg  (den_neg),
    .i_abs      (abs_r),
    .o_req      (mul_req[mul_pkg::MUL_REQ_SCALER]),
    .o_op_a     (sc_op_a),
    .o_op_b     (sc_op_b),
    .i_mul_valid(mul_valid[mul_pkg::MUL_REQ_SCALER]),
    .i_product  (product),
    .o_valid    (o_valid),
    .o_quot     (o_quot),
    .o_sat      (o_sat)
  );

  // Port 0 is the scaler, port 1 the engine
  mul_arbiter u_mul_arbiter (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_req    (mul_req),
    .i_op_a0  (sc_op_a),
    .i_op_b0  (sc_op_b),
    .i_op_a1  (eng_op_a),
    .i_op_b1  (eng_op_b),
    .o_valid  (mul_valid),
    .o_product(product)
  );

endmodule

// File: hdl/mul_arbiter.sv
/*
  Shared multiplier with fixed-priority arbiter
  Scaler beats the engine; product and one-hot strobe return a cycle later
*/
module mul_arbiter (
  input  logic                         clk,
  input  logic                         i_rst,
  input  logic [mul_pkg::MUL_NREQ-1:0] i_req,
  input  logic [fxp_pkg::FXP_W-1:0]    i_op_a0,
  input  logic [fxp_pkg::FXP_W-1:0]    i_op_b0,
  input  logic [fxp_pkg::FXP_W-1:0]    i_op_a1,
  input  logic [fxp_pkg::FXP_W-1:0]    i_op_b1,
  output logic [mul_pkg::MUL_NREQ-1:0] o_valid,
  output logic [mul_pkg::MUL_PW-1:0]   o_product
);

  logic [mul_pkg::MUL_NREQ-1:0] grant;
  logic [fxp_pkg::FXP_W-1:0]    op_a, op_b;

  always_comb begin
    grant = '0;
    if (i_req[mul_pkg::MUL_REQ_SCALER]) begin
      grant[mul_pkg::MUL_REQ_SCALER] = 1'b1;   // Highest priority
    end else if (i_req[mul_pkg::MUL_REQ_RECIP]) begin
      grant[mul_pkg::MUL_REQ_RECIP] = 1'b1;
    end
  end

  // Operand mux follows the grant
  assign op_a = grant[mul_pkg::MUL_REQ_RECIP] ? i_op_a1 : i_op_a0;
  assign op_b = grant[mul_pkg::MUL_REQ_RECIP] ? i_op_b1 : i_op_b0;

  always_ff @(posedge clk) begin
    if (i_rst) o_valid <= '0;
    else       o_valid <= grant;      // Strobe back to the winner
  end

  always_ff @(posedge clk) begin
    if (|grant) begin
      o_product <= $signed(op_a) * $signed(op_b);  // Q24.24
    end
  end

  // A losing engine keeps its request and operands for the next try
  a_hold_while_waiting: assert property (@(posedge clk) disable iff (i_rst)
    (i_req[mul_pkg::MUL_REQ_RECIP] && !grant[mul_pkg::MUL_REQ_RECIP])
      |=> (i_req[mul_pkg::MUL_REQ_RECIP] && $stable(i_op_a1) && $stable(i_op_b1)));

endmodule

// File: hdl/quot_scaler.sv
/*
  Quotient scaler
  Multiplies |num| by the reciprocal, saturates and restores the sign
*/
module quot_scaler (
  input  logic                       clk,
  input  logic                       i_rst,
  input  logic                       i_load,
  input  logic [fxp_pkg::FXP_W-1:0]  i_num,
  input  logic [fxp_pkg::FXP_W-1:0]  i_recip,
  input  logic                       i_recip_sat,
  input  logic                       i_den_neg,
  input  logic                       i_abs,
  output logic                       o_req,
  output logic [fxp_pkg::FXP_W-1:0]  o_op_a,
  output logic [fxp_pkg::FXP_W-1:0]  o_op_b,
  input  logic                       i_mul_valid,
  input  logic [mul_pkg::MUL_PW-1:0] i_product,
  output logic                       o_valid,
  output logic [fxp_pkg::FXP_W-1:0]  o_quot,
  output logic                       o_sat
);

  logic                      busy;           // Holds one item
  logic [fxp_pkg::FXP_W-1:0] num_mag;
  logic [fxp_pkg::FXP_W-1:0] num_r, recip_r;
  logic                      rsat_r, neg_r;
  logic                      sat;
  logic [fxp_pkg::FXP_W-1:0] mag;

  assign num_mag = i_num[fxp_pkg::FXP_W-1] ? (~i_num + 1'b1) : i_num;

  assign o_req  = busy && !i_mul_valid;  // Dropped in the strobe cycle
  assign o_op_a = num_r;
  assign o_op_b = recip_r;

  // Anything at or above the slice's sign bit means overflow
  assign sat = (|i_product[mul_pkg::MUL_PW-1:fxp_pkg::FXP_N+fxp_pkg::FXP_W-1])
               || (rsat_r && (num_r != '0));
  assign mag = sat ? fxp_pkg::FXP_SAT
                   : i_product[fxp_pkg::FXP_N+fxp_pkg::FXP_W-1:fxp_pkg::FXP_N];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy    <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      o_valid <= busy && i_mul_valid;
      if (i_load) busy <= 1'b1;
      else if (i_mul_valid) busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_load) begin
      num_r   <= num_mag;
      recip_r <= i_recip;
      rsat_r  <= i_recip_sat;
      neg_r   <= (i_num[fxp_pkg::FXP_W-1] ^ i_den_neg) && !i_abs;  // Sign to restore
    end
    if (busy && i_mul_valid) begin
      o_quot <= neg_r ? (~mag + 1'b1) : mag;
      o_sat  <= sat;
    end
  end

  // Engine must not deliver before this multiply is done
  a_load_when_free: assert property (@(posedge clk) disable iff (i_rst)
    i_load |-> !busy);

endmodule

// File: hdl/recip_engine.sv
/*
  Reciprocal engine
  Normalises |den| to [0.5,1), runs the c and e multiplies on the shared
  multiplier, then applies the x4 saturation and the lzc rescale
*/
module recip_engine (
  input  logic                          clk,
  input  logic                          i_rst,
  input  logic                          i_start,
  input  logic [fxp_pkg::FXP_W-1:0]     i_den,
  output logic                          o_ready,
  output logic                          o_req,
  output logic [fxp_pkg::FXP_W-1:0]     o_op_a,
  output logic [fxp_pkg::FXP_W-1:0]     o_op_b,
  input  logic                          i_mul_valid,
  input  logic [mul_pkg::MUL_PW-1:0]    i_product,
  output logic                          o_recip_valid,
  output logic [fxp_pkg::FXP_W-1:0]     o_recip,
  output logic                          o_recip_sat,
  output logic                          o_den_neg
);

  logic [fxp_pkg::FXP_W-1:0]     den_mag;      // |i_den| in the start cycle
  logic [fxp_pkg::FXP_LZC_W-1:0] lzc_cnt;
  logic [fxp_pkg::FXP_W-1:0]     a_comb, b_comb;
  logic [fxp_pkg::FXP_W-1:0]     a_r, b_r, c_r, e_r;
  logic [fxp_pkg::FXP_LZC_W-1:0] lzc_r;
  logic                          neg_r;
  logic                          c_wait;       // c requested, product pending
  logic                          e_wait;       // e requested, product pending
  logic                          out_r;        // Reciprocal strobe
  logic                          idle;
  logic [fxp_pkg::FXP_W-1:0]     prod_q;       // Q12.12 slice of the product
  logic [fxp_pkg::FXP_W-1:0]     d_prod, d_reg;
  logic [fxp_pkg::FXP_W-1:0]     reci;         // 4 * e, saturated
  logic [fxp_pkg::FXP_LZC_W-1:0] rescale_lzc, rescale_up;
  logic [2*fxp_pkg::FXP_W-1:0]   rescale_data;

  assign den_mag = i_den[fxp_pkg::FXP_W-1] ? (~i_den + 1'b1) : i_den;

  lzc u_lzc (
    .i_data(den_mag),
    .o_lzc (lzc_cnt)
  );

  // Bring the leading one to bit 11, i.e. into [0.5,1)
  always_comb begin
    if (lzc_cnt <= fxp_pkg::FXP_LZC_W'(fxp_pkg::FXP_M)) begin
      a_comb = den_mag >> (fxp_pkg::FXP_LZC_W'(fxp_pkg::FXP_M) - lzc_cnt);
    end else begin
      a_comb = den_mag << (lzc_cnt - fxp_pkg::FXP_LZC_W'(fxp_pkg::FXP_M));
    end
  end

  assign b_comb = fxp_pkg::FXP_K1466 - a_comb;  // b = 1.466 - a

  assign prod_q = i_product[fxp_pkg::FXP_N+fxp_pkg::FXP_W-1:fxp_pkg::FXP_N];
  assign d_prod = fxp_pkg::FXP_K10012 - prod_q;  // d from c as it returns
  assign d_reg  = fxp_pkg::FXP_K10012 - c_r;     // d while e waits for a grant

  assign idle    = !(c_wait || e_wait || out_r);
  assign o_ready = idle;

  // Request port, operands held as levels until the valid strobe
  always_comb begin
    o_req  = 1'b0;
    o_op_a = a_comb;        // Start cycle uses the fresh normalised value
    o_op_b = b_comb;
    if (c_wait) begin
      o_req  = 1'b1;        // Either c again or e right behind it
      o_op_a = i_mul_valid ? d_prod : a_r;
      o_op_b = b_r;
    end else if (e_wait) begin
      o_req  = !i_mul_valid;
      o_op_a = d_reg;
      o_op_b = b_r;
    end else if (idle) begin
      o_req  = i_start;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      c_wait <= 1'b0;
      e_wait <= 1'b0;
      out_r  <= 1'b0;
    end else begin
      out_r <= e_wait && i_mul_valid;
      if (idle && i_start) begin
        c_wait <= 1'b1;
      end else if (c_wait && i_mul_valid) begin
        c_wait <= 1'b0;
        e_wait <= 1'b1;     // e request already raised this cycle
      end else if (e_wait && i_mul_valid) begin
        e_wait <= 1'b0;
      end
    end
  end

  // Operand and intermediate registers
  always_ff @(posedge clk) begin
    if (idle && i_start) begin
      a_r   <= a_comb;
      b_r   <= b_comb;
      lzc_r <= lzc_cnt;
      neg_r <= i_den[fxp_pkg::FXP_W-1];
    end
    if (c_wait && i_mul_valid) c_r <= prod_q;
    if (e_wait && i_mul_valid) e_r <= prod_q;
  end

  // Top two bits would be lost by the shift left by two
  assign reci = (|e_r[fxp_pkg::FXP_W-1:fxp_pkg::FXP_W-2]) ? fxp_pkg::FXP_SAT : (e_r << 2);

  // Positive means the denominator was above one, so shift the result down
  assign rescale_lzc = fxp_pkg::FXP_LZC_W'(fxp_pkg::FXP_M) - lzc_r;
  assign rescale_up  = ~rescale_lzc + 1'b1;

  always_comb begin
    if (rescale_lzc[fxp_pkg::FXP_LZC_W-1]) begin
      rescale_data = {{fxp_pkg::FXP_W{1'b0}}, reci} << rescale_up;
    end else begin
      rescale_data = {{fxp_pkg::FXP_W{1'b0}}, reci} >> rescale_lzc;
    end
  end

  assign o_recip_sat   = |rescale_data[2*fxp_pkg::FXP_W-1:fxp_pkg::FXP_W];  // Overflow
  assign o_recip       = o_recip_sat ? fxp_pkg::FXP_SAT
                                     : rescale_data[fxp_pkg::FXP_W-1:0];
  assign o_recip_valid = out_r;
  assign o_den_neg     = neg_r;

  // Arbiter only answers requests this engine has raised
  a_no_valid_idle: assert property (@(posedge clk) disable iff (i_rst)
    idle |-> !i_mul_valid);

endmodule

// File: hdl/lzc.sv
/*
  Leading-zero counter
  Priority encoder over one non-negative Q12.12 magnitude, gives 24 for zero
*/
module lzc (
  input  logic [fxp_pkg::FXP_W-1:0]     i_data,
  output logic [fxp_pkg::FXP_LZC_W-1:0] o_lzc
);

  always_comb begin
    o_lzc = fxp_pkg::FXP_LZC_W'(fxp_pkg::FXP_W);  // All zero
    // Walk up from the LSB so the highest set bit is the last to write
    for (int i = 0; i < fxp_pkg::FXP_W; i++) begin
      if (i_data[i]) begin
        o_lzc = fxp_pkg::FXP_LZC_W'(fxp_pkg::FXP_W - 1 - i);
      end
    end
  end

endmodule

// File: hdl/mul_pkg.sv
/*
  Shared multiplier package
  Requester count, fixed priority order and product width
*/
package mul_pkg;

  localparam int MUL_NREQ = 2;        // Quotient scaler and reciprocal engine

  // Lower index wins arbitration
  localparam int MUL_REQ_SCALER = 0;
  localparam int MUL_REQ_RECIP  = 1;

  localparam int MUL_PW = 48;         // Full signed 24x24 product, Q24.24

endpackage

// File: hdl/fxp_pkg.sv
/*
  Fixed-point format package for the Q12.12 divider
  Word layout, saturation value and the constants of the reciprocal method
*/
package fxp_pkg;

  localparam int FXP_M = 12;              // Integer bits, sign included
  localparam int FXP_N = 12;              // Fractional bits
  localparam int FXP_W = FXP_M + FXP_N;   // Full word, 24 bits

  // Leading-zero count must reach FXP_W for a zero word
  localparam int FXP_LZC_W = 5;

  // Largest positive word; every saturated result is this or its negation
  localparam logic [FXP_W-1:0] FXP_SAT = {1'b0, {(FXP_W-1){1'b1}}};

  /*
    Reciprocal of a in [0.5,1):
      b = 1.466 - a, c = a * b, d = 1.0012 - c, e = d * b, 1/a ~ 4 * e
  */
  localparam logic [FXP_W-1:0] FXP_K1466 =
    FXP_W'($rtoi(1.466 * (2.0 ** FXP_N)));  // 1.466, truncated to Q12.12

  localparam logic [FXP_W-1:0] FXP_K10012 =
    FXP_W'($rtoi(1.0012 * (2.0 ** FXP_N))); // 1.0012, truncated to Q12.12

endpackage
